// File: verilog/ik_macros.svh
/* fixed-point format and step schedule for the two-joint DLS core.
   slot values count enabled cycles from the input sample at count 0 */
`ifndef IK_MACROS_SVH
`define IK_MACROS_SVH

// q_t word format
`define IK_W     18
`define IK_FRAC  12

// enabled cycles per step, counter wraps after this
`define IK_PERIOD  48

// restoring divider iterations for the reciprocal
`define IK_DIV_CYC  24

// multiplier request slots
`define IK_T_JJT  1
`define IK_T_DET  5
`define IK_T_ADJ  33
`define IK_T_DLS  37
`define IK_T_ERR  40

// divider runs from here for IK_DIV_CYC slots
`define IK_T_DIV  8

// o_delta and o_valid appear in this slot
`define IK_T_OUT  43

`endif

// File: verilog/ik_pkg.sv
/* signed fixed-point types, width and fraction set in ik_macros.svh.
   no saturation anywhere; sums wrap at the word width */
`include "ik_macros.svh"

package ik_pkg;

	// one fixed-point value
	typedef logic signed [`IK_W-1:0] q_t;

	// index 0 is x, or joint 1
	typedef q_t [1:0] vec2_t;

	// indexed [row][col]
	typedef q_t [1:0][1:0] mat2_t;

	// multiplier operation
	typedef enum logic {
		MM_MATRIX = 1'b0,
		MM_ELEM   = 1'b1
	} mm_mode_e;

endpackage

// File: verilog/mat_mult.sv
/* shared 2x2 multiplier, inputs registered at T, result visible at T+2.
   products are shifted right arithmetically, so they round toward minus infinity */
`timescale 1ns/1ns
`include "ik_macros.svh"

module mat_mult
	import ik_pkg::*;
(
	input  logic     i,
	input  logic     i_rst_n,
	input  logic     i_en,
	input  mm_mode_e i_mode,
	input  mat2_t    i_a,
	input  mat2_t    i_b,
	output mat2_t    o_result
);

	mat2_t    a_q;
	mat2_t    b_q;
	mm_mode_e mode_q;
	mat2_t    result_d;

	logic signed [2*`IK_W-1:0] prod0 [2][2];
	logic signed [2*`IK_W-1:0] prod1 [2][2];
	logic signed [2*`IK_W:0]   sum   [2][2];
	logic signed [2*`IK_W:0]   shifted [2][2];

	// element mode uses only the first multiplier of each cell
	always_comb begin
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				if (mode_q == MM_ELEM) begin
					prod0[r][c] = a_q[r][c] * b_q[r][c];
					prod1[r][c] = '0;
				end else begin
					prod0[r][c] = a_q[r][0] * b_q[0][c];
					prod1[r][c] = a_q[r][1] * b_q[1][c];
				end
				sum[r][c] = prod0[r][c] + prod1[r][c];
				shifted[r][c] = sum[r][c] >>> `IK_FRAC;
				result_d[r][c] = shifted[r][c][`IK_W-1:0];
			end
		end
	end

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			a_q <= '0;
			b_q <= '0;
			mode_q <= MM_MATRIX;
			o_result <= '0;
		end else if (i_en) begin
			a_q <= i_a;
			b_q <= i_b;
			mode_q <= i_mode;
			o_result <= result_d;
		end
	end

endmodule

// File: verilog/jjt_bias.sv
/* forms A = J*J^T + damp*I once per step, A holds from slot 4 to the next slot 3.
   request outputs are zero outside slot IK_T_JJT */
`timescale 1ns/1ns
`include "ik_macros.svh"

module jjt_bias
	import ik_pkg::*;
(
	input  logic       i,
	input  logic       i_rst_n,
	input  logic       i_en,
	input  logic [5:0] i_count,
	input  mat2_t      i_jac,
	input  q_t         i_damp,
	input  mat2_t      i_mm_result,
	output mat2_t      o_mm_a,
	output mat2_t      o_mm_b,
	output mat2_t      o_jjt
);

	// J on the left, its transpose on the right
	always_comb begin
		o_mm_a = '0;
		o_mm_b = '0;
		if (i_count == `IK_T_JJT) begin
			o_mm_a = i_jac;
			for (int r = 0; r < 2; r++) begin
				for (int c = 0; c < 2; c++) begin
					o_mm_b[r][c] = i_jac[c][r];
				end
			end
		end
	end

	// product is on the bus two slots after the request
	always_ff @(posedge i) begin
		if (i_en && i_count == `IK_T_JJT + 2) begin
			o_jjt[0][0] <= i_mm_result[0][0] + i_damp;
			o_jjt[0][1] <= i_mm_result[0][1];
			o_jjt[1][0] <= i_mm_result[1][0];
			o_jjt[1][1] <= i_mm_result[1][1] + i_damp;
		end
	end

	// off-diagonal terms use the same products in the shared multiplier
	a_jjt_symmetric: assert property (
		@(posedge i) disable iff (!i_rst_n)
		(i_count > `IK_T_JJT + 2) |-> (o_jjt[0][1] == o_jjt[1][0])
	);

endmodule

// File: verilog/inv2.sv
/* 2x2 inverse through determinant and reciprocal 2^(2*FRAC)/det, clamped to q_t max.
   det <= 0 raises o_singular and zeroes the reciprocal, so the inverse is zero */
`timescale 1ns/1ns
`include "ik_macros.svh"

module inv2
	import ik_pkg::*;
(
	input  logic       i,
	input  logic       i_rst_n,
	input  logic       i_en,
	input  logic [5:0] i_count,
	input  mat2_t      i_mat,
	input  mat2_t      i_mm_result,
	output mat2_t      o_mm_a,
	output mat2_t      o_mm_b,
	output mat2_t      o_inverse,
	output logic       o_singular
);

	q_t det_w;
	q_t det_q;
	q_t recip_w;
	q_t recip_q;

	logic                   busy;
	logic [4:0]             iter;
	logic [`IK_W-1:0]       rem;
	logic [`IK_W-1:0]       rem_sh;
	logic [`IK_DIV_CYC-1:0] quot;

	// a00*a11 and a01*a10 come back in row 0
	assign det_w = i_mm_result[0][0] - i_mm_result[0][1];

	// next dividend bit is always 0, only the leading 1 is nonzero
	assign rem_sh = {rem[`IK_W-2:0], 1'b0};

	always_comb begin
		if (|quot[`IK_DIV_CYC-1:`IK_W-1]) begin
			recip_w = {1'b0, {(`IK_W-1){1'b1}}};
		end else begin
			recip_w = quot[`IK_W-1:0];
		end
	end

	always_comb begin
		o_mm_a = '0;
		o_mm_b = '0;
		if (i_count == `IK_T_DET) begin
			o_mm_a[0][0] = i_mat[0][0];
			o_mm_b[0][0] = i_mat[1][1];
			o_mm_a[0][1] = i_mat[0][1];
			o_mm_b[0][1] = i_mat[1][0];
		end else if (i_count == `IK_T_ADJ) begin
			// adjugate times recip, element by element
			o_mm_a[0][0] = i_mat[1][1];
			o_mm_a[0][1] = -i_mat[0][1];
			o_mm_a[1][0] = -i_mat[1][0];
			o_mm_a[1][1] = i_mat[0][0];
			o_mm_b = {4{recip_q}};
		end
	end

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			busy <= 1'b0;
			iter <= '0;
			o_singular <= 1'b0;
		end else if (i_en) begin
			if (i_count == `IK_T_DET + 2) begin
				o_singular <= (det_w <= 0);
				busy <= (det_w > 0);
				iter <= '0;
			end else if (busy) begin
				iter <= iter + 1'b1;
				if (iter == `IK_DIV_CYC - 1) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// remainder starts at 1, the leading bit of 2^(2*FRAC)
	always_ff @(posedge i) begin
		if (i_en) begin
			if (i_count == `IK_T_DET + 2) begin
				det_q <= det_w;
				rem <= 1;
				quot <= '0;
			end else if (busy) begin
				if (rem_sh >= det_q) begin
					rem <= rem_sh - det_q;
					quot <= {quot[`IK_DIV_CYC-2:0], 1'b1};
				end else begin
					rem <= rem_sh;
					quot <= {quot[`IK_DIV_CYC-2:0], 1'b0};
				end
			end
			if (i_count == `IK_T_DIV + `IK_DIV_CYC) begin
				recip_q <= o_singular ? '0 : recip_w;
			end
			if (i_count == `IK_T_ADJ + 2) begin
				o_inverse <= i_mm_result;
			end
		end
	end

	a_div_window: assert property (
		@(posedge i) disable iff (!i_rst_n)
		busy |-> (i_count >= `IK_T_DIV && i_count <= `IK_T_DIV + `IK_DIV_CYC)
	);

endmodule

// File: verilog/ik_dls.sv
/* one damped-least-squares IK step every IK_PERIOD enabled cycles, inputs sampled at count 0.
   o_valid is a single-clock strobe in slot IK_T_OUT; o_delta holds until the next one */
`timescale 1ns/1ns
`include "ik_macros.svh"

module ik_dls
	import ik_pkg::*;
(
	input  logic  i,
	input  logic  i_rst_n,
	input  logic  i_en,
	input  mat2_t i_jac,
	input  q_t    i_damp,
	input  vec2_t i_target,
	input  vec2_t i_pos,
	output vec2_t o_delta,
	output logic  o_valid,
	output logic  o_singular
);

	logic [5:0] count;

	mat2_t jac_q;
	q_t    damp_q;
	vec2_t target_q;
	vec2_t pos_q;

	vec2_t err;
	mat2_t err_m;
	mat2_t jac_t;
	mat2_t dls_q;
	mat2_t jjt;
	mat2_t inverse;
	logic  inv_singular;

	mat2_t    jjt_a, jjt_b;
	mat2_t    inv_a, inv_b;
	mat2_t    dls_a, dls_b;
	mat2_t    mm_a, mm_b;
	mat2_t    mm_result;
	mm_mode_e mm_mode;
	logic [2:0] req_active;

	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			count <= '0;
		end else if (i_en) begin
			if (count == `IK_PERIOD - 1) begin
				count <= '0;
			end else begin
				count <= count + 1'b1;
			end
		end
	end

	// inputs are frozen for the whole step
	always_ff @(posedge i) begin
		if (i_en && count == 0) begin
			jac_q <= i_jac;
			damp_q <= i_damp;
			target_q <= i_target;
			pos_q <= i_pos;
		end
	end

	// error copied into both columns, only column 0 is used
	always_comb begin
		for (int k = 0; k < 2; k++) begin
			err[k] = target_q[k] - pos_q[k];
			err_m[k][0] = err[k];
			err_m[k][1] = err[k];
		end
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				jac_t[r][c] = jac_q[c][r];
			end
		end
	end

	jjt_bias jjt_bias_i (
		.i           (i),
		.i_rst_n     (i_rst_n),
		.i_en        (i_en),
		.i_count     (count),
		.i_jac       (jac_q),
		.i_damp      (damp_q),
		.i_mm_result (mm_result),
		.o_mm_a      (jjt_a),
		.o_mm_b      (jjt_b),
		.o_jjt       (jjt)
	);

	inv2 inv2_i (
		.i           (i),
		.i_rst_n     (i_rst_n),
		.i_en        (i_en),
		.i_count     (count),
		.i_mat       (jjt),
		.i_mm_result (mm_result),
		.o_mm_a      (inv_a),
		.o_mm_b      (inv_b),
		.o_inverse   (inverse),
		.o_singular  (inv_singular)
	);

	// J^T * inverse, then DLS * error
	always_comb begin
		dls_a = '0;
		dls_b = '0;
		if (count == `IK_T_DLS) begin
			dls_a = jac_t;
			dls_b = inverse;
		end else if (count == `IK_T_ERR) begin
			dls_a = dls_q;
			dls_b = err_m;
		end
	end

	// idle requesters drive zero
	assign mm_a = jjt_a | inv_a | dls_a;
	assign mm_b = jjt_b | inv_b | dls_b;
	assign mm_mode = (count == `IK_T_DET || count == `IK_T_ADJ) ? MM_ELEM : MM_MATRIX;

	mat_mult mat_mult_i (
		.i        (i),
		.i_rst_n  (i_rst_n),
		.i_en     (i_en),
		.i_mode   (mm_mode),
		.i_a      (mm_a),
		.i_b      (mm_b),
		.o_result (mm_result)
	);

	always_ff @(posedge i) begin
		if (i_en && count == `IK_T_DLS + 2) begin
			dls_q <= mm_result;
		end
	end

	// valid is a strobe, so it follows the clock and not i_en
	always_ff @(posedge i) begin
		if (!i_rst_n) begin
			o_valid <= 1'b0;
			o_delta <= '0;
			o_singular <= 1'b0;
		end else begin
			o_valid <= i_en && (count == `IK_T_OUT - 1);
			if (i_en && count == `IK_T_OUT - 1) begin
				o_singular <= inv_singular;
				o_delta[0] <= inv_singular ? '0 : mm_result[0][0];
				o_delta[1] <= inv_singular ? '0 : mm_result[1][0];
			end
		end
	end

	assign req_active = {|{jjt_a, jjt_b}, |{inv_a, inv_b}, |{dls_a, dls_b}};

	a_one_requester: assert property (
		@(posedge i) disable iff (!i_rst_n)
		$onehot0(req_active)
	);

endmodule

// File: sim/tb_clk.sv
/* 20 ns clock, reset held low for the first RST_CYCLES rising edges.
   i_rst_req pulls the reset low again for as long as it is high */
`timescale 1ns/1ns

module tb_clk #(
	parameter int HALF_NS    = 10,
	parameter int RST_CYCLES = 4
) (
	input  logic i_rst_req,
	output logic o_clk,
	output logic o_rst_n
);

	logic por_n;
	int   rst_cnt;

	initial begin
		o_clk = 1'b0;
		por_n = 1'b0;
		rst_cnt = 0;
	end

	always #(HALF_NS) o_clk = ~o_clk;

	// power-on reset released on the last of the reset edges
	always @(posedge o_clk) begin
		if (rst_cnt < RST_CYCLES - 1) begin
			rst_cnt <= rst_cnt + 1;
		end else begin
			por_n <= 1'b1;
		end
	end

	assign o_rst_n = por_n & ~i_rst_req;

endmodule

// File: sim/tb_ik.sv
/* random DLS steps into ik_dls, each result checked against an integer model.
   stalls and one reset in the middle of a step come from the LFSR, so runs repeat */
`timescale 1ns/1ns
`include "ik_macros.svh"

module tb_ik
	import ik_pkg::*;
();

	localparam int     N_STEPS     = 12;
	localparam int     MIN_RESULTS = N_STEPS - 1;
	localparam longint WATCHDOG_NS = longint'(N_STEPS + 4) * `IK_PERIOD * 20;
	localparam int     QMAX        = (1 << (`IK_W - 1)) - 1;

	logic  i;
	logic  i_rst_n;
	logic  rst_req;
	logic  i_en;
	mat2_t i_jac;
	q_t    i_damp;
	vec2_t i_target;
	vec2_t i_pos;
	vec2_t o_delta;
	logic  o_valid;
	logic  o_singular;

	logic [31:0] lfsr_state;
	logic [5:0]  model_count;
	logic        exp_valid;
	vec2_t       exp_delta;
	logic        exp_singular;
	vec2_t       pending_delta;
	logic        pending_singular;
	vec2_t       ref_delta;
	logic        ref_singular;
	int          valid_seen;

	tb_clk clk_gen_i (
		.i_rst_req (rst_req),
		.o_clk     (i),
		.o_rst_n   (i_rst_n)
	);

	ik_dls dut_i (
		.i          (i),
		.i_rst_n    (i_rst_n),
		.i_en       (i_en),
		.i_jac      (i_jac),
		.i_damp     (i_damp),
		.i_target   (i_target),
		.i_pos      (i_pos),
		.o_delta    (o_delta),
		.o_valid    (o_valid),
		.o_singular (o_singular)
	);

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// n-bit two's complement draw, sign extended
	task automatic draw_signed(input int n, output q_t v);
		logic [31:0]        b;
		logic signed [31:0] s;
		draw_bits(n, b);
		s = b << (32 - n);
		s = s >>> (32 - n);
		v = s[`IK_W-1:0];
	endtask

	// two products summed, shifted toward minus infinity, wrapped to the word
	function automatic q_t fx_mac(input q_t a0, input q_t b0, input q_t a1, input q_t b1);
		longint s;
		s = longint'(a0) * longint'(b0) + longint'(a1) * longint'(b1);
		s = s >>> `IK_FRAC;
		return s[`IK_W-1:0];
	endfunction

	task automatic dls_reference(input mat2_t jac, input q_t damp, input vec2_t target,
			input vec2_t pos, output vec2_t delta, output logic singular);
		mat2_t  a;
		mat2_t  inv;
		mat2_t  dls;
		vec2_t  e;
		q_t     det;
		q_t     recip;
		longint quot;
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				a[r][c] = fx_mac(jac[r][0], jac[c][0], jac[r][1], jac[c][1]);
			end
		end
		a[0][0] = a[0][0] + damp;
		a[1][1] = a[1][1] + damp;
		det = fx_mac(a[0][0], a[1][1], 0, 0) - fx_mac(a[0][1], a[1][0], 0, 0);
		singular = (det <= 0);
		recip = '0;
		if (!singular) begin
			quot = (longint'(1) << (2 * `IK_FRAC)) / longint'(det);
			if (quot > QMAX) begin
				recip = QMAX;
			end else begin
				recip = quot[`IK_W-1:0];
			end
		end
		// adjugate scaled by the reciprocal
		inv[0][0] = fx_mac(a[1][1], recip, 0, 0);
		inv[0][1] = fx_mac(-a[0][1], recip, 0, 0);
		inv[1][0] = fx_mac(-a[1][0], recip, 0, 0);
		inv[1][1] = fx_mac(a[0][0], recip, 0, 0);
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				dls[r][c] = fx_mac(jac[0][r], inv[0][c], jac[1][r], inv[1][c]);
			end
		end
		for (int k = 0; k < 2; k++) begin
			e[k] = target[k] - pos[k];
		end
		for (int r = 0; r < 2; r++) begin
			delta[r] = singular ? q_t'(0) : fx_mac(dls[r][0], e[0], dls[r][1], e[1]);
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp_v,
			input logic [63:0] act_v);
		$display("[FAIL] %s expected %0h actual %0h", name, exp_v, act_v);
		$display("STATUS: FAIL");
		$fatal(1, "check on %s failed", name);
	endtask

	// jacobian in +-1.0, damping 0.05 to 0.5, error in +-0.5
	task automatic drive_inputs(input bit zero_err);
		mat2_t       jac;
		vec2_t       pos;
		vec2_t       tgt;
		q_t          v;
		logic [31:0] b;
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < 2; c++) begin
				draw_signed(13, v);
				jac[r][c] = v;
			end
		end
		for (int k = 0; k < 2; k++) begin
			draw_signed(13, v);
			pos[k] = v;
			draw_signed(12, v);
			tgt[k] = zero_err ? pos[k] : pos[k] + v;
		end
		draw_bits(11, b);
		i_jac <= jac;
		i_pos <= pos;
		i_target <= tgt;
		i_damp <= q_t'(205 + b % 1844);
	endtask

	// one period of enabled cycles, offsets of -1 leave out the stall or reset
	task automatic run_step(input bit zero_err, input int stall_at, input int stall_len,
			input int reset_at);
		for (int n = 0; n < `IK_PERIOD; n++) begin
			if (n == stall_at) begin
				for (int k = 0; k < stall_len; k++) begin
					@(posedge i);
					drive_inputs(zero_err);
					i_en <= 1'b0;
					rst_req <= 1'b0;
				end
			end
			@(posedge i);
			drive_inputs(zero_err);
			i_en <= 1'b1;
			rst_req <= (reset_at >= 0) && (n == reset_at || n == reset_at + 1);
		end
	endtask

	// schedule model, counts enabled cycles from the sample at count 0
	always @(posedge i) begin
		if (!i_rst_n) begin
			model_count <= '0;
			exp_valid <= 1'b0;
			exp_delta <= '0;
			exp_singular <= 1'b0;
		end else begin
			exp_valid <= i_en && (model_count == `IK_T_OUT - 1);
			if (i_en) begin
				if (model_count == 0) begin
					dls_reference(i_jac, i_damp, i_target, i_pos, ref_delta, ref_singular);
					pending_delta <= ref_delta;
					pending_singular <= ref_singular;
				end
				if (model_count == `IK_T_OUT - 1) begin
					exp_delta <= pending_delta;
					exp_singular <= pending_singular;
				end
				model_count <= (model_count == `IK_PERIOD - 1) ? 6'd0 : model_count + 6'd1;
			end
		end
	end

	always @(posedge i) begin
		if (o_valid) begin
			valid_seen <= valid_seen + 1;
		end
	end

	a_valid_timing: assert property (@(posedge i) disable iff (!i_rst_n) o_valid == exp_valid)
		else report_mismatch("o_valid", $sampled(exp_valid), $sampled(o_valid));

	a_delta_value: assert property (@(posedge i) disable iff (!i_rst_n) o_delta == exp_delta)
		else report_mismatch("o_delta", $sampled(exp_delta), $sampled(o_delta));

	a_singular_flag: assert property (
		@(posedge i) disable iff (!i_rst_n) o_singular == exp_singular
	) else report_mismatch("o_singular", $sampled(exp_singular), $sampled(o_singular));

	// damping is always positive here
	a_not_singular: assert property (@(posedge i) disable iff (!i_rst_n) o_valid |-> !o_singular)
		else report_mismatch("o_singular", 64'h0, $sampled(o_singular));

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the test sequence ended", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		logic [31:0] b;
		int          stall_at;
		int          stall_len;
		int          reset_at;
		lfsr_state = 32'hb0e8_b368;
		valid_seen = 0;
		rst_req = 1'b0;
		i_en = 1'b0;
		i_jac = '0;
		i_damp = '0;
		i_target = '0;
		i_pos = '0;
		@(posedge i);
		while (!i_rst_n) begin
			@(posedge i);
		end
		for (int s = 0; s < N_STEPS; s++) begin
			stall_at = -1;
			stall_len = 0;
			reset_at = -1;
			if (s >= 4 && s < 8) begin
				draw_bits(5, b);
				stall_at = 4 + b;
				draw_bits(3, b);
				stall_len = 1 + b;
			end
			if (s == 9) begin
				draw_bits(5, b);
				reset_at = 8 + b;
			end
			// zero error reaches the sample that opens step 2
			run_step(s == 1, stall_at, stall_len, reset_at);
		end
		run_step(1'b0, -1, 0, -1);
		@(posedge i);
		i_en <= 1'b0;
		repeat (2) @(posedge i);
		if (valid_seen >= MIN_RESULTS) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("only %0d results seen, at least %0d expected", valid_seen, MIN_RESULTS);
			$display("STATUS: FAIL");
			$fatal(1, "too few results");
		end
	end

endmodule

// File: sim.f
+incdir+verilog
verilog/ik_pkg.sv
verilog/mat_mult.sv
verilog/jjt_bias.sv
verilog/inv2.sv
verilog/ik_dls.sv
sim/tb_clk.sv
sim/tb_ik.sv

// File: Makefile
# Verilator build and run of the ik_dls testbench

VERILATOR ?= verilator
TOP       ?= tb_ik
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= STATUS: PASS
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
